// ==== rtl/bcd_cfg_pkg.sv ====
//----------------------------------------------------------------------------
// Binary-to-BCD converter configuration: sizes, operand, digit and result types
//----------------------------------------------------------------------------
package bcd_cfg_pkg;

    // ------------------------------------------------------------------------
    // Converter sizes
    // ------------------------------------------------------------------------
    // Unsigned operand width
    localparam int BIN_WIDTH   = 16;
    // Bits per BCD digit
    localparam int DIGIT_W     = 4;
    // Five digits cover 65535
    localparam int BCD_DIGITS  = 5;
    // Entries in each queue
    localparam int FIFO_DEPTH  = 4;
    localparam int FIFO_PTR_W  = $clog2(FIFO_DEPTH);
    // One shift per operand bit
    localparam int SHIFT_CNT_W = $clog2(BIN_WIDTH);

    // ------------------------------------------------------------------------
    // Types
    // ------------------------------------------------------------------------
    typedef logic [BIN_WIDTH-1:0]            bin_t;
    typedef logic [DIGIT_W-1:0]              digit_t;
    // Least significant digit in the low nibble
    typedef logic [BCD_DIGITS*DIGIT_W-1:0]   bcd_t;
    // Significant digit count, 1 to BCD_DIGITS
    typedef logic [$clog2(BCD_DIGITS+1)-1:0] ndig_t;
    // Queue fill level, 0 to FIFO_DEPTH
    typedef logic [$clog2(FIFO_DEPTH+1)-1:0] count_t;
    typedef logic [FIFO_PTR_W-1:0]           fifo_ptr_t;
    typedef logic [SHIFT_CNT_W-1:0]          shift_cnt_t;

    // Converted value plus digit count for display blanking
    typedef struct packed {
        bcd_t  digits;
        ndig_t ndigits;
    } bcd_result_t;

endpackage

// ==== rtl/wb_pkg.sv ====
//----------------------------------------------------------------------------
// Wishbone classic bus structs and the converter register map
//----------------------------------------------------------------------------
package wb_pkg;

    // Bus widths, word addressed
    localparam int ADR_W = 2;
    localparam int DAT_W = 32;

    typedef logic [ADR_W-1:0] wb_adr_t;
    typedef logic [DAT_W-1:0] wb_dat_t;

    // Master to slave
    typedef struct packed {
        logic    cyc;
        logic    stb;
        logic    we;
        wb_adr_t adr;
        wb_dat_t dat;
    } wb_req_t;

    // Slave to master
    typedef struct packed {
        logic    ack;
        wb_dat_t dat;
    } wb_rsp_t;

    // ------------------------------------------------------------------------
    // Register map (word addresses, address 3 unmapped)
    // ------------------------------------------------------------------------
    localparam wb_adr_t ADR_DATA   = 2'd0;
    localparam wb_adr_t ADR_RESULT = 2'd1;
    localparam wb_adr_t ADR_STATUS = 2'd2;

    // RESULT word fields
    localparam int RES_DIGITS_LSB = 0;
    localparam int RES_NDIG_LSB   = 24;
    localparam int RES_VALID_BIT  = 31;

    // STATUS word fields
    localparam int STAT_REQ_LSB   = 0;
    localparam int STAT_RES_LSB   = 4;
    localparam int STAT_BUSY_BIT  = 8;
    localparam int STAT_OVF_BIT   = 9;

endpackage

// ==== rtl/bcd_fifo.sv ====
//----------------------------------------------------------------------------
// Synchronous register-array queue, payload type set by parameter
//----------------------------------------------------------------------------
module bcd_fifo #(
    parameter type payload_t = logic
) (
    input  logic                 clk,
    input  logic                 rst,
    // Write side
    input  logic                 push,
    input  payload_t             push_data,
    output logic                 full,
    // Read side with the head shown combinationally
    input  logic                 pop,
    output logic                 valid,
    output payload_t             data,
    // Occupancy
    output bcd_cfg_pkg::count_t  count
);

    // Entry storage
    payload_t                mem [bcd_cfg_pkg::FIFO_DEPTH];

    bcd_cfg_pkg::fifo_ptr_t  wr_ptr;
    bcd_cfg_pkg::fifo_ptr_t  rd_ptr;
    bcd_cfg_pkg::count_t     count_q;

    logic                    do_push;
    logic                    do_pop;

    // Push while full and pop while empty are dropped
    assign do_push = push && !full;
    assign do_pop  = pop && valid;

    assign full  = (count_q == bcd_cfg_pkg::count_t'(bcd_cfg_pkg::FIFO_DEPTH));
    assign valid = (count_q != '0);
    assign data  = mem[rd_ptr];
    assign count = count_q;

    // Payload write
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // ------------------------------------------------------------------------
    // Pointers and occupancy
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count_q <= '0;
        end else begin
            // Depth is a power of two so the pointers wrap naturally
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves the level unchanged
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

// ==== rtl/bcd_shift_add3.sv ====
//----------------------------------------------------------------------------
// Sequential double dabble engine, one bit per cycle, with digit count
//----------------------------------------------------------------------------
module bcd_shift_add3 (
    input  logic                      clk,
    input  logic                      rst,
    // Operand in
    input  logic                      in_valid,
    input  bcd_cfg_pkg::bin_t         in_data,
    output logic                      in_ready,
    // Result out
    output logic                      out_valid,
    output bcd_cfg_pkg::bcd_result_t  out_data,
    input  logic                      out_ready,
    // Operand accepted and result not yet taken
    output logic                      busy
);

    // Idle, shifting, counting digits, holding the result
    typedef enum logic [1:0] {
        S_IDLE,
        S_SHIFT,
        S_COUNT,
        S_DONE
    } state_t;

    state_t                    state_q;
    bcd_cfg_pkg::shift_cnt_t   cnt_q;
    bcd_cfg_pkg::bin_t         bin_q;
    bcd_cfg_pkg::bcd_t         digit_q;
    bcd_cfg_pkg::bcd_t         digit_corr;
    bcd_cfg_pkg::bcd_t         digit_shift;
    bcd_cfg_pkg::ndig_t        ndig_next;
    bcd_cfg_pkg::bcd_result_t  result_q;

    // Digits 5..9 get 3 added so the next shift carries into the next digit
    function automatic bcd_cfg_pkg::digit_t add3(input bcd_cfg_pkg::digit_t d);
        return (d >= 4'd5) ? d + 4'd3 : d;
    endfunction

    // ------------------------------------------------------------------------
    // Per-digit correction, then shift in the next operand bit
    // ------------------------------------------------------------------------
    for (genvar g = 0; g < bcd_cfg_pkg::BCD_DIGITS; g++) begin : g_add3
        assign digit_corr[g*bcd_cfg_pkg::DIGIT_W +: bcd_cfg_pkg::DIGIT_W] =
            add3(digit_q[g*bcd_cfg_pkg::DIGIT_W +: bcd_cfg_pkg::DIGIT_W]);
    end

    // Top bit of the corrected digits never set for a 16-bit operand
    assign digit_shift = {digit_corr[$bits(bcd_cfg_pkg::bcd_t)-2:0],
                          bin_q[bcd_cfg_pkg::BIN_WIDTH-1]};

    // Highest nonzero digit position plus one, at least one
    always_comb begin
        ndig_next = bcd_cfg_pkg::ndig_t'(1);
        for (int i = 1; i < bcd_cfg_pkg::BCD_DIGITS; i++) begin
            if (digit_q[i*bcd_cfg_pkg::DIGIT_W +: bcd_cfg_pkg::DIGIT_W] != '0) begin
                ndig_next = bcd_cfg_pkg::ndig_t'(i + 1);
            end
        end
    end

    // ------------------------------------------------------------------------
    // Control FSM
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= S_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (in_valid) begin
                        state_q <= S_SHIFT;
                        cnt_q   <= '0;
                    end
                end
                S_SHIFT: begin
                    cnt_q <= cnt_q + 1'b1;
                    // Last operand bit shifted on this edge
                    if (cnt_q == bcd_cfg_pkg::shift_cnt_t'(bcd_cfg_pkg::BIN_WIDTH - 1)) begin
                        state_q <= S_COUNT;
                    end
                end
                S_COUNT: begin
                    state_q <= S_DONE;
                end
                S_DONE: begin
                    // Held until the result queue takes it
                    if (out_ready) begin
                        state_q <= S_IDLE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // Datapath registers
    always_ff @(posedge clk) begin
        if (state_q == S_IDLE && in_valid) begin
            bin_q   <= in_data;
            digit_q <= '0;
        end else if (state_q == S_SHIFT) begin
            bin_q   <= bin_q << 1;
            digit_q <= digit_shift;
        end
        if (state_q == S_COUNT) begin
            result_q.digits  <= digit_q;
            result_q.ndigits <= ndig_next;
        end
    end

    assign in_ready  = (state_q == S_IDLE);
    assign out_valid = (state_q == S_DONE);
    assign out_data  = result_q;
    assign busy      = (state_q != S_IDLE);

endmodule

// ==== rtl/bcd_wb_regs.sv ====
//----------------------------------------------------------------------------
// Wishbone classic slave for the converter registers and queue access
//----------------------------------------------------------------------------
module bcd_wb_regs (
    input  logic                      clk,
    input  logic                      rst,
    // Bus port
    input  wb_pkg::wb_req_t           wb_req,
    output wb_pkg::wb_rsp_t           wb_rsp,
    // Request queue write side
    output logic                      req_push,
    output bcd_cfg_pkg::bin_t         req_data,
    input  logic                      req_full,
    input  bcd_cfg_pkg::count_t       req_count,
    // Result queue read side
    output logic                      res_pop,
    input  logic                      res_valid,
    input  bcd_cfg_pkg::bcd_result_t  res_data,
    input  bcd_cfg_pkg::count_t       res_count,
    // Engine state
    input  logic                      busy
);

    logic             ack_q;
    logic             ovf_q;
    wb_pkg::wb_dat_t  rd_dat_q;
    wb_pkg::wb_dat_t  rd_next;

    logic             start;
    logic             wr_data;
    logic             rd_result;
    logic             wr_status;

    // ------------------------------------------------------------------------
    // Access decode
    // ------------------------------------------------------------------------
    // New request seen only outside the ack cycle
    assign start = wb_req.cyc && wb_req.stb && !ack_q;

    assign wr_data   = start && wb_req.we && (wb_req.adr == wb_pkg::ADR_DATA);
    assign rd_result = start && !wb_req.we && (wb_req.adr == wb_pkg::ADR_RESULT);
    assign wr_status = start && wb_req.we && (wb_req.adr == wb_pkg::ADR_STATUS);

    // Queue strobes land on the same edge that raises ack
    assign req_push = wr_data && !req_full;
    assign req_data = wb_req.dat[bcd_cfg_pkg::BIN_WIDTH-1:0];
    assign res_pop  = rd_result && res_valid;

    // Read data mux
    always_comb begin
        rd_next = '0;
        if (!wb_req.we) begin
            case (wb_req.adr)
                wb_pkg::ADR_RESULT: begin
                    // Empty queue reads as all zero
                    if (res_valid) begin
                        rd_next[wb_pkg::RES_DIGITS_LSB +: $bits(bcd_cfg_pkg::bcd_t)] =
                            res_data.digits;
                        rd_next[wb_pkg::RES_NDIG_LSB +: $bits(bcd_cfg_pkg::ndig_t)] =
                            res_data.ndigits;
                        rd_next[wb_pkg::RES_VALID_BIT] = 1'b1;
                    end
                end
                wb_pkg::ADR_STATUS: begin
                    rd_next[wb_pkg::STAT_REQ_LSB +: $bits(bcd_cfg_pkg::count_t)] = req_count;
                    rd_next[wb_pkg::STAT_RES_LSB +: $bits(bcd_cfg_pkg::count_t)] = res_count;
                    rd_next[wb_pkg::STAT_BUSY_BIT] = busy;
                    rd_next[wb_pkg::STAT_OVF_BIT]  = ovf_q;
                end
                // DATA reads and the unmapped word return zero
                default: rd_next = '0;
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // Ack and sticky overflow
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            ack_q <= 1'b0;
            ovf_q <= 1'b0;
        end else begin
            // Single-cycle ack one cycle after the request
            ack_q <= start;
            if (wr_data && req_full) begin
                ovf_q <= 1'b1;
            end else if (wr_status && wb_req.dat[wb_pkg::STAT_OVF_BIT]) begin
                ovf_q <= 1'b0;
            end
        end
    end

    // Read data captured with the ack
    always_ff @(posedge clk) begin
        if (start) begin
            rd_dat_q <= rd_next;
        end
    end

    assign wb_rsp.ack = ack_q;
    assign wb_rsp.dat = rd_dat_q;

endmodule

// ==== rtl/bcd_conv_top.sv ====
//----------------------------------------------------------------------------
// Binary-to-BCD peripheral: bus slave, request and result queues, engine
//----------------------------------------------------------------------------
module bcd_conv_top (
    input  logic             clk,
    input  logic             rst,
    input  wb_pkg::wb_req_t  wb_req,
    output wb_pkg::wb_rsp_t  wb_rsp
);

    // Request path
    logic                      req_push;
    bcd_cfg_pkg::bin_t         req_data;
    logic                      req_full;
    bcd_cfg_pkg::count_t       req_count;
    logic                      req_valid;
    bcd_cfg_pkg::bin_t         req_head;
    logic                      eng_in_ready;

    // Result path
    logic                      eng_out_valid;
    bcd_cfg_pkg::bcd_result_t  eng_out_data;
    logic                      res_full;
    logic                      res_pop;
    logic                      res_valid;
    bcd_cfg_pkg::bcd_result_t  res_data;
    bcd_cfg_pkg::count_t       res_count;
    logic                      busy;

    bcd_wb_regs u_regs (
        .clk       (clk),
        .rst       (rst),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .req_push  (req_push),
        .req_data  (req_data),
        .req_full  (req_full),
        .req_count (req_count),
        .res_pop   (res_pop),
        .res_valid (res_valid),
        .res_data  (res_data),
        .res_count (res_count),
        .busy      (busy)
    );

    // Operands waiting for the engine
    bcd_fifo #(.payload_t(bcd_cfg_pkg::bin_t)) u_req_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (req_push),
        .push_data (req_data),
        .full      (req_full),
        .pop       (eng_in_ready),
        .valid     (req_valid),
        .data      (req_head),
        .count     (req_count)
    );

    bcd_shift_add3 u_engine (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (req_valid),
        .in_data   (req_head),
        .in_ready  (eng_in_ready),
        .out_valid (eng_out_valid),
        .out_data  (eng_out_data),
        .out_ready (!res_full),
        .busy      (busy)
    );

    // Finished results waiting for the host
    bcd_fifo #(.payload_t(bcd_cfg_pkg::bcd_result_t)) u_res_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (eng_out_valid),
        .push_data (eng_out_data),
        .full      (res_full),
        .pop       (res_pop),
        .valid     (res_valid),
        .data      (res_data),
        .count     (res_count)
    );

endmodule

// ==== bench/bcd_conv_assert.sv ====
//----------------------------------------------------------------------------
// Wishbone ack and result queue protocol assertions for the converter top
//----------------------------------------------------------------------------
module bcd_conv_assert (
    input logic                 clk,
    input logic                 rst,
    input wb_pkg::wb_req_t      wb_req,
    input wb_pkg::wb_rsp_t      wb_rsp,
    input logic                 out_valid,
    input logic                 res_full,
    input bcd_cfg_pkg::count_t  res_count
);
    timeunit 1ns;
    timeprecision 100ps;

    // Failed assertions so far
    int fail_cnt;

    initial fail_cnt = 0;

    // Ack needs a request on the cycle before
    ack_after_req: assert property (@(posedge clk) disable iff (rst)
        wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb))
        else begin
            fail_cnt++;
            $error("ack raised without a request on the previous cycle");
        end

    // Single-cycle ack
    ack_one_cycle: assert property (@(posedge clk) disable iff (rst)
        wb_rsp.ack |=> !wb_rsp.ack)
        else begin
            fail_cnt++;
            $error("ack held for two cycles");
        end

    // A full result queue never grows
    res_no_overfill: assert property (@(posedge clk) disable iff (rst)
        res_full |=> res_count <= $past(res_count))
        else begin
            fail_cnt++;
            $error("result queue accepted a push while full");
        end

    // Engine result held until the queue takes it
    out_valid_hold: assert property (@(posedge clk) disable iff (rst)
        out_valid && res_full |=> out_valid)
        else begin
            fail_cnt++;
            $error("engine dropped out_valid before the result was accepted");
        end

endmodule

bind bcd_conv_top bcd_conv_assert u_assert (
    .clk       (clk),
    .rst       (rst),
    .wb_req    (wb_req),
    .wb_rsp    (wb_rsp),
    .out_valid (eng_out_valid),
    .res_full  (res_full),
    .res_count (res_count)
);

// ==== bench/bcd_conv_tb.sv ====
//----------------------------------------------------------------------------
// Directed testbench for the Wishbone binary-to-BCD peripheral
//----------------------------------------------------------------------------
module bcd_conv_tb;
    timeunit 1ns;
    timeprecision 100ps;

    // Ack wait in cycles and polls per wait
    localparam int BUS_TIMEOUT  = 20;
    localparam int POLL_TIMEOUT = 100;

    // Decoded STATUS word
    typedef struct packed {
        bcd_cfg_pkg::count_t req;
        bcd_cfg_pkg::count_t res;
        logic                busy;
        logic                ovf;
    } status_t;

    logic             clk;
    logic             rst;
    wb_pkg::wb_req_t  wb_req;
    wb_pkg::wb_rsp_t  wb_rsp;

    int err_cnt;
    int tmo_cnt;
    int seed;

    bcd_conv_top dut (
        .clk    (clk),
        .rst    (rst),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    // 20 ns clock
    initial clk = 1'b0;
    always #10 clk = ~clk;

    // ------------------------------------------------------------------------
    // Reference model and checks
    // ------------------------------------------------------------------------
    // Digits by repeated division by ten
    function automatic bcd_cfg_pkg::bcd_result_t ref_convert(input bcd_cfg_pkg::bin_t v);
        bcd_cfg_pkg::bcd_result_t r;
        int                       rem;
        rem = int'(v);
        r = '0;
        // Zero still shows one digit
        r.ndigits = bcd_cfg_pkg::ndig_t'(1);
        for (int i = 0; i < bcd_cfg_pkg::BCD_DIGITS; i++) begin
            r.digits[i*bcd_cfg_pkg::DIGIT_W +: bcd_cfg_pkg::DIGIT_W] =
                bcd_cfg_pkg::digit_t'(rem % 10);
            if (rem % 10 != 0) begin
                r.ndigits = bcd_cfg_pkg::ndig_t'(i + 1);
            end
            rem = rem / 10;
        end
        return r;
    endfunction

    task automatic check_result(input string name, input bcd_cfg_pkg::bcd_result_t exp,
                                input bcd_cfg_pkg::bcd_result_t act,
                                input logic exp_v, input logic act_v);
        if (act !== exp) begin
            $display("Mismatch in %s: expected digits %h ndigits %0d, actual digits %h ndigits %0d",
                     name, exp.digits, exp.ndigits, act.digits, act.ndigits);
            err_cnt++;
        end
        if (act_v !== exp_v) begin
            $display("Mismatch in %s: expected valid %b, actual valid %b", name, exp_v, act_v);
            err_cnt++;
        end
    endtask

    task automatic check_status(input string name, input status_t exp, input status_t act);
        if (act !== exp) begin
            $display("Mismatch in %s: expected req %0d res %0d busy %b ovf %b, %s",
                     name, exp.req, exp.res, exp.busy, exp.ovf,
                     $sformatf("actual req %0d res %0d busy %b ovf %b",
                               act.req, act.res, act.busy, act.ovf));
            err_cnt++;
        end
    endtask

    // ------------------------------------------------------------------------
    // Bus access
    // ------------------------------------------------------------------------
    // Called 1 ns after a rising edge and returns 1 ns after the ack edge
    task automatic bus_cycle(input logic we, input wb_pkg::wb_adr_t adr,
                             input wb_pkg::wb_dat_t wdat, output wb_pkg::wb_dat_t rdat);
        int n;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = wdat;
        n = 0;
        do begin
            @(posedge clk);
            #1;
            n++;
        end while (!wb_rsp.ack && n < BUS_TIMEOUT);
        if (!wb_rsp.ack) begin
            $display("Timeout: bus %s at address %0d was never acknowledged",
                     we ? "write" : "read", adr);
            tmo_cnt++;
        end
        rdat   = wb_rsp.dat;
        // Drop the request once ack is seen
        wb_req = '0;
    endtask

    task automatic wb_write(input wb_pkg::wb_adr_t adr, input wb_pkg::wb_dat_t dat);
        wb_pkg::wb_dat_t unused;
        bus_cycle(1'b1, adr, dat, unused);
    endtask

    task automatic wb_read(input wb_pkg::wb_adr_t adr, output wb_pkg::wb_dat_t dat);
        bus_cycle(1'b0, adr, '0, dat);
    endtask

    task automatic read_status(output status_t st);
        wb_pkg::wb_dat_t w;
        wb_read(wb_pkg::ADR_STATUS, w);
        st.req  = w[wb_pkg::STAT_REQ_LSB +: $bits(bcd_cfg_pkg::count_t)];
        st.res  = w[wb_pkg::STAT_RES_LSB +: $bits(bcd_cfg_pkg::count_t)];
        st.busy = w[wb_pkg::STAT_BUSY_BIT];
        st.ovf  = w[wb_pkg::STAT_OVF_BIT];
    endtask

    // Poll RESULT until its valid bit is set
    task automatic poll_result(output bcd_cfg_pkg::bcd_result_t r, output logic v);
        wb_pkg::wb_dat_t w;
        int              n;
        n = 0;
        do begin
            wb_read(wb_pkg::ADR_RESULT, w);
            n++;
        end while (!w[wb_pkg::RES_VALID_BIT] && n < POLL_TIMEOUT);
        if (!w[wb_pkg::RES_VALID_BIT]) begin
            $display("Timeout: no converted result became readable");
            tmo_cnt++;
        end
        r.digits  = w[wb_pkg::RES_DIGITS_LSB +: $bits(bcd_cfg_pkg::bcd_t)];
        r.ndigits = w[wb_pkg::RES_NDIG_LSB +: $bits(bcd_cfg_pkg::ndig_t)];
        v         = w[wb_pkg::RES_VALID_BIT];
    endtask

    // Poll STATUS until queue levels and busy match
    task automatic wait_status(input status_t want);
        status_t st;
        int      n;
        n = 0;
        do begin
            read_status(st);
            n++;
        end while ({st.req, st.res, st.busy} !== {want.req, want.res, want.busy}
                   && n < POLL_TIMEOUT);
        if ({st.req, st.res, st.busy} !== {want.req, want.res, want.busy}) begin
            $display("Timeout: queue levels and busy never reached the awaited state");
            tmo_cnt++;
        end
    endtask

    // Poll STATUS until the request queue has a free entry
    task automatic wait_req_space();
        status_t st;
        int      n;
        n = 0;
        do begin
            read_status(st);
            n++;
        end while (st.req >= bcd_cfg_pkg::count_t'(bcd_cfg_pkg::FIFO_DEPTH)
                   && n < POLL_TIMEOUT);
        if (st.req >= bcd_cfg_pkg::count_t'(bcd_cfg_pkg::FIFO_DEPTH)) begin
            $display("Timeout: request queue never had a free entry");
            tmo_cnt++;
        end
    endtask

    // ------------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------------
    task automatic after_reset();
        status_t                  st;
        wb_pkg::wb_dat_t          w;
        bcd_cfg_pkg::bcd_result_t r;
        read_status(st);
        check_status("reset status", '0, st);
        wb_read(wb_pkg::ADR_RESULT, w);
        r.digits  = w[wb_pkg::RES_DIGITS_LSB +: $bits(bcd_cfg_pkg::bcd_t)];
        r.ndigits = w[wb_pkg::RES_NDIG_LSB +: $bits(bcd_cfg_pkg::ndig_t)];
        check_result("reset result", '0, r, 1'b0, w[wb_pkg::RES_VALID_BIT]);
        // Whole word must be zero, not only the decoded fields
        if (w !== '0) begin
            $display("Mismatch in reset result word: expected %h, actual %h", 32'h0, w);
            err_cnt++;
        end
    endtask

    task automatic corner_operands();
        bcd_cfg_pkg::bin_t        ops [6];
        bcd_cfg_pkg::bcd_result_t r;
        logic                     v;
        ops = '{16'd0, 16'd9, 16'd10, 16'd99, 16'd100, 16'd65535};
        foreach (ops[i]) begin
            wb_write(wb_pkg::ADR_DATA, wb_pkg::wb_dat_t'(ops[i]));
            poll_result(r, v);
            check_result($sformatf("corner %0d", ops[i]), ref_convert(ops[i]), r, 1'b1, v);
        end
    endtask

    // Nine operands fill engine and both queues and the tenth is dropped
    task automatic queue_backpressure();
        bcd_cfg_pkg::bin_t        ops [9];
        bcd_cfg_pkg::bcd_result_t r;
        logic                     v;
        status_t                  st;
        foreach (ops[i]) begin
            ops[i] = bcd_cfg_pkg::bin_t'(i * 7283 + 12);
            // Engine drains slower than the bus writes
            wait_req_space();
            wb_write(wb_pkg::ADR_DATA, wb_pkg::wb_dat_t'(ops[i]));
        end
        wait_status('{req: 3'd4, res: 3'd4, busy: 1'b1, ovf: 1'b0});
        read_status(st);
        check_status("full queues", '{req: 3'd4, res: 3'd4, busy: 1'b1, ovf: 1'b0}, st);
        wb_write(wb_pkg::ADR_DATA, 32'd4242);
        read_status(st);
        check_status("tenth write", '{req: 3'd4, res: 3'd4, busy: 1'b1, ovf: 1'b1}, st);
        foreach (ops[i]) begin
            poll_result(r, v);
            check_result($sformatf("backpressure %0d", i), ref_convert(ops[i]), r, 1'b1, v);
        end
    endtask

    task automatic overflow_clear();
        bcd_cfg_pkg::bcd_result_t r;
        logic                     v;
        status_t                  st;
        wb_write(wb_pkg::ADR_STATUS, 32'h1 << wb_pkg::STAT_OVF_BIT);
        read_status(st);
        check_status("overflow clear", '0, st);
        wb_write(wb_pkg::ADR_DATA, 32'd4321);
        poll_result(r, v);
        check_result("write after clear", ref_convert(16'd4321), r, 1'b1, v);
    endtask

    // Random operands with at most three in flight
    task automatic random_stream();
        bcd_cfg_pkg::bin_t        op;
        bcd_cfg_pkg::bcd_result_t exp_q [$];
        bcd_cfg_pkg::bcd_result_t r;
        logic                     v;
        int                       coin;
        status_t                  st;
        for (int i = 0; i < 30; i++) begin
            op = bcd_cfg_pkg::bin_t'($random(seed));
            coin = $random(seed);
            wb_write(wb_pkg::ADR_DATA, wb_pkg::wb_dat_t'(op));
            exp_q.push_back(ref_convert(op));
            if (exp_q.size() >= 3 || coin[0]) begin
                poll_result(r, v);
                check_result("random", exp_q.pop_front(), r, 1'b1, v);
            end
        end
        while (exp_q.size() > 0) begin
            poll_result(r, v);
            check_result("random drain", exp_q.pop_front(), r, 1'b1, v);
        end
        wait_status('0);
        read_status(st);
        check_status("random end", '0, st);
    endtask

    // ------------------------------------------------------------------------
    // Sequence and verdict
    // ------------------------------------------------------------------------
    initial begin
        err_cnt = 0;
        tmo_cnt = 0;
        seed    = 27;
        wb_req  = '0;
        rst     = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        after_reset();
        corner_operands();
        queue_backpressure();
        overflow_clear();
        random_stream();

        $display("Errors: %0d mismatches, %0d timeouts, %0d assertion failures",
                 err_cnt, tmo_cnt, dut.u_assert.fail_cnt);
        if (err_cnt == 0 && tmo_cnt == 0 && dut.u_assert.fail_cnt == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
rtl/bcd_cfg_pkg.sv
rtl/wb_pkg.sv
rtl/bcd_fifo.sv
rtl/bcd_shift_add3.sv
rtl/bcd_wb_regs.sv
rtl/bcd_conv_top.sv
bench/bcd_conv_assert.sv
bench/bcd_conv_tb.sv
